// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= rvc_fetch.f
TB_TOP    ?= fetch_tb
RTL_TOP   ?= fetch_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TB_TOP)
	@out="$$(./$(OBJ_DIR)/$(TB_TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== design/fetch_aligner.sv ====
`timescale 1ns/1ps

module fetch_aligner (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             advance_i,
    input  logic             flush_i,
    input  fetch_pkg::pc_t   pc_i,
    input  rvc_pkg::instr_t  mem_rdata_i,
    input  rvc_pkg::instr_t  expanded_i,
    output rvc_pkg::cinstr_t chalf_o,
    output fetch_pkg::pc_t   step_o,
    output rvc_pkg::instr_t  instr_o,
    output fetch_pkg::pc_t   instr_pc_next_o,
    output logic             valid_o
);
    import rvc_pkg::*;
    import fetch_pkg::*;

    align_state_e state_q;
    align_state_e state_d;
    half_t        half_buf_q;  // upper half of the previous word
    half_t        cur_half;
    logic         is_compressed;
    logic         deliver;
    instr_t       instr_d;

    // pc bit 0 selects the halfword inside the fetched word
    assign cur_half = pc_i[0] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

    assign chalf_o       = (state_q == ALIGN_SPLIT) ? half_buf_q : cur_half;
    assign is_compressed = (chalf_o[1:0] != QUADRANT_FULL);

    always_comb begin
        state_d = ALIGN_NORMAL;
        deliver = 1'b1;
        step_o  = pc_t'(1);
        instr_d = expanded_i;
        if (state_q == ALIGN_SPLIT) begin
            // pc sits on the following word, its low half completes the instruction
            instr_d = {mem_rdata_i[15:0], half_buf_q};
        end else if (!is_compressed) begin
            if (pc_i[0]) begin
                state_d = ALIGN_SPLIT;  // straddles the word boundary
                deliver = 1'b0;
            end else begin
                instr_d = mem_rdata_i;
                step_o  = pc_t'(2);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            state_q         <= ALIGN_NORMAL;
            half_buf_q      <= '0;
            instr_o         <= '0;
            instr_pc_next_o <= '0;
            valid_o         <= 1'b0;
        end else if (advance_i) begin
            state_q    <= state_d;
            half_buf_q <= mem_rdata_i[31:16];
            valid_o    <= deliver;
            if (deliver) begin
                instr_o         <= instr_d;
                // also right for a joined word, pc is then one past its low half
                instr_pc_next_o <= pc_i + step_o;
            end
        end
    end

endmodule

// ==== design/fetch_pc_gen.sv ====
`timescale 1ns/1ps

module fetch_pc_gen #(
    parameter fetch_pkg::pc_t RESET_PC = '0
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           advance_i,
    input  logic           flush_i,
    input  logic           redirect_valid_i,
    input  fetch_pkg::pc_t redirect_pc_i,
    input  fetch_pkg::pc_t step_i,  // in halfwords
    output fetch_pkg::pc_t pc_o
);
    import fetch_pkg::*;

    pc_t pc_q;
    pc_t pc_d;

    // a taken target from execute wins over the sequential step
    always_comb begin
        if (redirect_valid_i) begin
            pc_d = redirect_pc_i;
        end else begin
            pc_d = pc_q + step_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            pc_q <= RESET_PC;
        end else if (advance_i) begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;  // goes straight to memory

endmodule

// ==== design/fetch_pkg.sv ====
package fetch_pkg;

    // halfword address, byte address bit 0 is always zero and not stored
    typedef logic [30:0] pc_t;

    typedef logic [15:0] half_t;

    // aligner state
    typedef enum logic {
        ALIGN_NORMAL,  // no partial instruction pending
        ALIGN_SPLIT    // lower half of a 32-bit instruction sits in the buffer
    } align_state_e;

endpackage

// ==== design/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
    parameter fetch_pkg::pc_t RESET_PC = '0
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  logic            mem_wait_i,
    input  rvc_pkg::instr_t mem_rdata_i,
    input  logic            redirect_valid_i,
    input  fetch_pkg::pc_t  redirect_pc_i,
    output fetch_pkg::pc_t  mem_pc_o,
    output rvc_pkg::instr_t instr_o,
    output fetch_pkg::pc_t  instr_pc_next_o,
    output logic            valid_o
);
    import rvc_pkg::*;
    import fetch_pkg::*;

    logic    advance;
    pc_t     pc;
    pc_t     step;
    cinstr_t chalf;
    instr_t  expanded;
    logic    align_valid;

    assign advance  = ~stall_i & ~mem_wait_i;
    assign mem_pc_o = pc;

    // low while memory waits, so a word is only taken on an edge that also refills it
    assign valid_o = align_valid & ~mem_wait_i;

    fetch_pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .advance_i        (advance),
        .flush_i          (flush_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .step_i           (step),
        .pc_o             (pc)
    );

    fetch_aligner u_aligner (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .advance_i       (advance),
        .flush_i         (flush_i),
        .pc_i            (pc),
        .mem_rdata_i     (mem_rdata_i),
        .expanded_i      (expanded),
        .chalf_o         (chalf),
        .step_o          (step),
        .instr_o         (instr_o),
        .instr_pc_next_o (instr_pc_next_o),
        .valid_o         (align_valid)
    );

    rvc_expander u_expander (
        .chalf_i (chalf),
        .instr_o (expanded)
    );

endmodule

// ==== design/rvc_expander.sv ====
`timescale 1ns/1ps

module rvc_expander (
    input  rvc_pkg::cinstr_t chalf_i,
    output rvc_pkg::instr_t  instr_o
);
    import rvc_pkg::*;

    regnum_t rd;      // rd/rs1 full field
    regnum_t rs2;     // rs2 full field
    regnum_t rs1p;    // c[9:7] mapped to x8..x15
    regnum_t rs2p;    // c[4:2], rd' or rs2' depending on format
    funct3_t funct3;

    assign rd     = chalf_i[11:7];
    assign rs2    = chalf_i[6:2];
    assign rs1p   = {CPRIME_PREFIX, chalf_i[9:7]};
    assign rs2p   = {CPRIME_PREFIX, chalf_i[4:2]};
    assign funct3 = chalf_i[15:13];

    always_comb begin
        instr_o = '0;  // unknown or reserved encodings stay all zero
        case (chalf_i[1:0])
            2'b00: begin
                case (funct3)
                    3'b000: begin  // c.addi4spn, zero immediate is reserved
                        if (chalf_i[12:5] != 8'd0) begin
                            instr_o = {2'b00, chalf_i[10:7], chalf_i[12:11], chalf_i[5],
                                       chalf_i[6], 2'b00, REG_SP, F3_ADD, rs2p, OPC_OP_IMM};
                        end
                    end
                    3'b010: instr_o = {5'b0, chalf_i[5], chalf_i[12:10], chalf_i[6], 2'b00,
                                       rs1p, F3_WORD, rs2p, OPC_LOAD};  // c.lw
                    3'b110: instr_o = {5'b0, chalf_i[5], chalf_i[12], rs2p, rs1p, F3_WORD,
                                       chalf_i[11:10], chalf_i[6], 2'b00, OPC_STORE};  // c.sw
                    default: instr_o = '0;
                endcase
            end
            2'b01: begin
                case (funct3)
                    // c.addi, c.nop when rd is x0
                    3'b000: instr_o = {{7{chalf_i[12]}}, rs2, rd, F3_ADD, rd, OPC_OP_IMM};
                    3'b001, 3'b101: begin  // c.jal links to ra, c.j to x0
                        instr_o = {chalf_i[12], chalf_i[8], chalf_i[10:9], chalf_i[6],
                                   chalf_i[7], chalf_i[2], chalf_i[11], chalf_i[5:3],
                                   {9{chalf_i[12]}}, funct3[2] ? REG_ZERO : REG_RA, OPC_JAL};
                    end
                    3'b010: instr_o = {{7{chalf_i[12]}}, rs2, REG_ZERO, F3_ADD, rd,
                                       OPC_OP_IMM};  // c.li
                    3'b011: begin
                        if (rd == REG_SP) begin  // c.addi16sp
                            instr_o = {{3{chalf_i[12]}}, chalf_i[4:3], chalf_i[5], chalf_i[2],
                                       chalf_i[6], 4'b0, REG_SP, F3_ADD, REG_SP, OPC_OP_IMM};
                        end else begin  // c.lui
                            instr_o = {{15{chalf_i[12]}}, rs2, rd, OPC_LUI};
                        end
                    end
                    3'b100: begin
                        case (chalf_i[11:10])
                            2'b00: instr_o = {7'b0, rs2, rs1p, F3_SR, rs1p, OPC_OP_IMM};  // c.srli
                            2'b01: instr_o = {F7_ALT, rs2, rs1p, F3_SR, rs1p, OPC_OP_IMM};
                            2'b10: instr_o = {{7{chalf_i[12]}}, rs2, rs1p, F3_AND, rs1p,
                                              OPC_OP_IMM};  // c.andi
                            default: begin
                                // register-register group, c[12] set is RV64 only
                                if (!chalf_i[12]) begin
                                    case (chalf_i[6:5])
                                        2'b00: instr_o = {F7_ALT, rs2p, rs1p, F3_ADD, rs1p, OPC_OP};
                                        2'b01: instr_o = {7'b0, rs2p, rs1p, F3_XOR, rs1p, OPC_OP};
                                        2'b10: instr_o = {7'b0, rs2p, rs1p, F3_OR, rs1p, OPC_OP};
                                        default: instr_o = {7'b0, rs2p, rs1p, F3_AND, rs1p, OPC_OP};
                                    endcase
                                end
                            end
                        endcase
                    end
                    default: begin  // c.beqz / c.bnez, funct3[0] picks bne
                        instr_o = {{4{chalf_i[12]}}, chalf_i[6:5], chalf_i[2], REG_ZERO, rs1p,
                                   2'b00, chalf_i[13], chalf_i[11:10], chalf_i[4:3],
                                   chalf_i[12], OPC_BRANCH};
                    end
                endcase
            end
            2'b10: begin
                case (funct3)
                    3'b000: instr_o = {7'b0, rs2, rd, F3_SLL, rd, OPC_OP_IMM};  // c.slli
                    3'b010: instr_o = {4'b0, chalf_i[3:2], chalf_i[12], chalf_i[6:4], 2'b00,
                                       REG_SP, F3_WORD, rd, OPC_LOAD};  // c.lwsp
                    3'b100: begin
                        if (!chalf_i[12]) begin
                            if (rs2 == REG_ZERO) begin  // c.jr
                                instr_o = {12'b0, rd, F3_ADD, REG_ZERO, OPC_JALR};
                            end else begin  // c.mv
                                instr_o = {7'b0, rs2, REG_ZERO, F3_ADD, rd, OPC_OP};
                            end
                        end else if (rs2 == REG_ZERO && rd == REG_ZERO) begin
                            instr_o = {12'd1, REG_ZERO, F3_ADD, REG_ZERO, OPC_SYSTEM};  // c.ebreak
                        end else if (rs2 == REG_ZERO) begin  // c.jalr
                            instr_o = {12'b0, rd, F3_ADD, REG_RA, OPC_JALR};
                        end else begin  // c.add
                            instr_o = {7'b0, rs2, rd, F3_ADD, rd, OPC_OP};
                        end
                    end
                    3'b110: instr_o = {4'b0, chalf_i[8:7], chalf_i[12], rs2, REG_SP, F3_WORD,
                                       chalf_i[11:9], 2'b00, OPC_STORE};  // c.swsp
                    default: instr_o = '0;
                endcase
            end
            default: instr_o = '0;  // quadrant 3 is not compressed
        endcase
    end

endmodule

// ==== design/rvc_pkg.sv ====
package rvc_pkg;

    typedef logic [31:0] instr_t;   // full RV32 instruction word
    typedef logic [15:0] cinstr_t;  // compressed instruction
    typedef logic [6:0]  opcode_t;
    typedef logic [4:0]  regnum_t;
    typedef logic [2:0]  funct3_t;

    // major opcodes
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // funct fields used by the expanded forms
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_WORD = 3'b010;  // lw / sw
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;
    localparam logic [6:0] F7_ALT = 7'b0100000;  // sub / srai

    localparam regnum_t REG_ZERO = 5'd0;
    localparam regnum_t REG_RA   = 5'd1;
    localparam regnum_t REG_SP   = 5'd2;

    localparam logic [1:0] CPRIME_PREFIX = 2'b01;  // rd'/rs1'/rs2' map to x8..x15
    localparam logic [1:0] QUADRANT_FULL = 2'b11;

endpackage

// ==== rvc_fetch.f ====
design/rvc_pkg.sv
design/fetch_pkg.sv
design/rvc_expander.sv
design/fetch_aligner.sv
design/fetch_pc_gen.sv
design/fetch_top.sv
tb/tb_clock_gen.sv
tb/fetch_tb.sv

// ==== tb/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;
    import rvc_pkg::*;
    import fetch_pkg::*;

    localparam pc_t RESET_PC       = 31'h40;  // byte address 0x80
    localparam int  MEM_HALVES     = 256;
    localparam int  CLK_PERIOD     = 10;
    localparam int  RESET_CYCLES   = 10;
    localparam int  EXPECTED_INSTR = 67;      // sum over all tests
    localparam int  WATCHDOG_NS    = (EXPECTED_INSTR * 20 + RESET_CYCLES) * CLK_PERIOD;

    logic   clk;
    logic   rst_n;
    logic   stall;
    logic   flush;
    logic   mem_wait;
    instr_t mem_rdata;
    logic   redirect_valid;
    pc_t    redirect_pc;
    pc_t    mem_pc;
    instr_t instr;
    pc_t    instr_pc_next;
    logic   valid;

    half_t      mem [MEM_HALVES];
    logic [7:0] word_base;

    instr_t exp_instr[$];
    pc_t    exp_next[$];
    instr_t got_instr[$];
    pc_t    got_next[$];
    int     base;     // first result of the current test in the got queues
    pc_t    load_pc;
    int     checks;
    int     errors;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fetch_top #(
        .RESET_PC (RESET_PC)
    ) dut (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .stall_i          (stall),
        .flush_i          (flush),
        .mem_wait_i       (mem_wait),
        .mem_rdata_i      (mem_rdata),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .mem_pc_o         (mem_pc),
        .instr_o          (instr),
        .instr_pc_next_o  (instr_pc_next),
        .valid_o          (valid)
    );

    // aligned word around the requested halfword, junk while memory waits
    assign word_base = {mem_pc[7:1], 1'b0};
    assign mem_rdata = mem_wait ? 32'hdead_beef : {mem[word_base + 8'd1], mem[word_base]};

    // an instruction is taken on an edge where the stage advances
    always @(negedge clk) begin
        if (rst_n && !flush && valid && !stall) begin
            got_instr.push_back(instr);
            got_next.push_back(instr_pc_next);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: fetch stopped delivering instructions, %0d errors so far", errors);
        $display("** FAIL **");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
        logic signed [31:0] t;
        t = $signed(v << (32 - bits));
        return t >>> (32 - bits);
    endfunction

    function automatic regnum_t creg(input logic [2:0] p);
        return {2'b01, p};  // x8..x15
    endfunction

    // standard RV32 formats
    function automatic instr_t enc_i(input logic [31:0] imm, input regnum_t rs1,
                                     input logic [2:0] f3, input regnum_t rd,
                                     input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_r(input logic [6:0] f7, input regnum_t rs2,
                                     input regnum_t rs1, input logic [2:0] f3,
                                     input regnum_t rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic instr_t enc_s(input logic [31:0] imm, input regnum_t rs2,
                                     input regnum_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};  // sw only
    endfunction

    function automatic instr_t enc_b(input logic [31:0] imm, input regnum_t rs1,
                                     input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic instr_t enc_j(input logic [31:0] imm, input regnum_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < MEM_HALVES; i++) begin
            mem[i] = {i[7:0], ~i[7:0]};
        end
    endtask

    task automatic begin_test(input string name);
        $display("running %s", name);
        fill_memory();
        exp_instr.delete();
        exp_next.delete();
        load_pc = RESET_PC;
    endtask

    task automatic emit16(input cinstr_t c, input instr_t full);
        mem[load_pc[7:0]] = c;
        exp_instr.push_back(full);
        exp_next.push_back(load_pc + pc_t'(1));
        load_pc = load_pc + pc_t'(1);
    endtask

    task automatic emit32(input instr_t w);
        mem[load_pc[7:0]] = w[15:0];
        mem[load_pc[7:0] + 8'd1] = w[31:16];
        exp_instr.push_back(w);
        exp_next.push_back(load_pc + pc_t'(2));
        load_pc = load_pc + pc_t'(2);
    endtask

    // flush back to RESET_PC and start a fresh result window
    task automatic restart();
        @(posedge clk);
        #1;
        flush = 1'b1;
        base  = got_instr.size();
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic run_stream(input logic random_hold);
        while (got_instr.size() - base < exp_instr.size()) begin
            @(posedge clk);
            #1;
            stall    = random_hold && ($urandom % 3 == 0);
            mem_wait = random_hold && ($urandom % 4 == 0);
        end
        stall    = 1'b0;
        mem_wait = 1'b0;
        for (int i = 0; i < exp_instr.size(); i++) begin
            check_value($sformatf("instr_o[%0d]", i), got_instr[base + i], exp_instr[i]);
            check_value($sformatf("instr_pc_next_o[%0d]", i), 32'(got_next[base + i]),
                        32'(exp_next[i]));
        end
    endtask

    task automatic test_aligned_stream();
        begin_test("aligned 32-bit stream");
        for (int i = 0; i < 8; i++) begin
            emit32($urandom | 32'h3);
        end
        restart();
        run_stream(1'b0);
    endtask

    task automatic test_compressed();
        regnum_t     rd;
        regnum_t     rs;
        logic [2:0]  p1;
        logic [2:0]  p2;
        logic [31:0] imm;
        begin_test("compressed expansion");
        rd = 5'(3 + $urandom % 29);  // never x0 or sp
        rs = 5'(1 + $urandom % 31);
        p1 = 3'($urandom);
        p2 = 3'($urandom);
        imm = ($urandom % 255 + 1) << 2;
        emit16({3'b000, imm[5:4], imm[9:6], imm[2], imm[3], p2, 2'b00},
               enc_i(imm, 5'd2, 3'b000, creg(p2), 7'h13));  // addi4spn
        imm = ($urandom % 32) << 2;
        emit16({3'b010, imm[5:3], p1, imm[2], imm[6], p2, 2'b00},
               enc_i(imm, creg(p1), 3'b010, creg(p2), 7'h03));  // lw
        emit16({3'b110, imm[5:3], p1, imm[2], imm[6], p2, 2'b00},
               enc_s(imm, creg(p2), creg(p1)));  // sw
        emit16(16'h0001, 32'h0000_0013);  // nop
        imm = sext($urandom, 6);
        emit16({3'b000, imm[5], rd, imm[4:0], 2'b01}, enc_i(imm, rd, 3'b000, rd, 7'h13));
        emit16({3'b010, imm[5], rd, imm[4:0], 2'b01}, enc_i(imm, 5'd0, 3'b000, rd, 7'h13));
        emit16({3'b100, imm[5], 2'b10, p1, imm[4:0], 2'b01},
               enc_i(imm, creg(p1), 3'b111, creg(p1), 7'h13));  // andi
        imm = sext($urandom & 32'hffe, 12);
        emit16({3'b001, imm[11], imm[4], imm[9:8], imm[10], imm[6], imm[7], imm[3:1],
                imm[5], 2'b01}, enc_j(imm, 5'd1));  // jal
        emit16({3'b101, imm[11], imm[4], imm[9:8], imm[10], imm[6], imm[7], imm[3:1],
                imm[5], 2'b01}, enc_j(imm, 5'd0));  // j
        imm = sext((($urandom % 63) + 1) << 4, 10);
        emit16({3'b011, imm[9], 5'd2, imm[4], imm[6], imm[8:7], imm[5], 2'b01},
               enc_i(imm, 5'd2, 3'b000, 5'd2, 7'h13));  // addi16sp
        imm = sext($urandom % 63 + 1, 6);
        emit16({3'b011, imm[5], rd, imm[4:0], 2'b01}, {imm[19:0], rd, 7'h37});  // lui
        imm = $urandom % 32;
        emit16({3'b100, 1'b0, 2'b00, p1, imm[4:0], 2'b01},
               enc_i(imm, creg(p1), 3'b101, creg(p1), 7'h13));  // srli
        emit16({3'b100, 1'b0, 2'b01, p1, imm[4:0], 2'b01},
               enc_i(imm | 32'h400, creg(p1), 3'b101, creg(p1), 7'h13));  // srai
        emit16({3'b000, 1'b0, rd, imm[4:0], 2'b10}, enc_i(imm, rd, 3'b001, rd, 7'h13));
        emit16({6'b100011, p1, 2'b00, p2, 2'b01}, enc_r(7'h20, creg(p2), creg(p1), 3'b000, creg(p1)));
        emit16({6'b100011, p1, 2'b01, p2, 2'b01}, enc_r(7'h00, creg(p2), creg(p1), 3'b100, creg(p1)));
        emit16({6'b100011, p1, 2'b10, p2, 2'b01}, enc_r(7'h00, creg(p2), creg(p1), 3'b110, creg(p1)));
        emit16({6'b100011, p1, 2'b11, p2, 2'b01}, enc_r(7'h00, creg(p2), creg(p1), 3'b111, creg(p1)));
        imm = sext($urandom & 32'h1fe, 9);
        emit16({3'b110, imm[8], imm[4:3], p1, imm[7:6], imm[2:1], imm[5], 2'b01},
               enc_b(imm, creg(p1), 3'b000));  // beqz
        emit16({3'b111, imm[8], imm[4:3], p1, imm[7:6], imm[2:1], imm[5], 2'b01},
               enc_b(imm, creg(p1), 3'b001));  // bnez
        imm = ($urandom % 64) << 2;
        emit16({3'b010, imm[5], rd, imm[4:2], imm[7:6], 2'b10},
               enc_i(imm, 5'd2, 3'b010, rd, 7'h03));  // lwsp
        emit16({3'b110, imm[5:2], imm[7:6], rs, 2'b10}, enc_s(imm, rs, 5'd2));  // swsp
        emit16({4'b1000, rd, 5'd0, 2'b10}, enc_i(32'd0, rd, 3'b000, 5'd0, 7'h67));  // jr
        emit16({4'b1000, rd, rs, 2'b10}, enc_r(7'h00, rs, 5'd0, 3'b000, rd));       // mv
        emit16(16'h9002, 32'h0010_0073);  // ebreak
        emit16({4'b1001, rd, 5'd0, 2'b10}, enc_i(32'd0, rd, 3'b000, 5'd1, 7'h67));  // jalr
        emit16({4'b1001, rd, rs, 2'b10}, enc_r(7'h00, rs, rd, 3'b000, rd));         // add
        emit16(16'h0000, 32'h0000_0000);  // reserved encoding
        restart();
        run_stream(1'b0);
    endtask

    // three of the full instructions straddle a word boundary
    task automatic load_mixed_program();
        emit16(16'h0001, 32'h0000_0013);
        emit32($urandom | 32'h3);
        emit32($urandom | 32'h3);
        emit16(16'h9002, 32'h0010_0073);
        emit32($urandom | 32'h3);
        emit32($urandom | 32'h3);
        emit16(16'h0001, 32'h0000_0013);
        emit32($urandom | 32'h3);
    endtask

    task automatic test_split();
        begin_test("split instruction");
        load_mixed_program();
        restart();
        run_stream(1'b0);
    endtask

    task automatic test_redirect();
        pc_t target;
        begin_test("redirect");
        for (int i = 0; i < 3; i++) begin
            emit32($urandom | 32'h3);
        end
        target  = RESET_PC + pc_t'(33);  // upper half of a word
        load_pc = target;
        emit16(16'h0001, 32'h0000_0013);
        emit32($urandom | 32'h3);
        emit32($urandom | 32'h3);
        emit16(16'h9002, 32'h0010_0073);
        restart();
        while (mem_pc != RESET_PC + pc_t'(4)) begin
            @(posedge clk);
            #1;
        end
        redirect_pc    = target;
        redirect_valid = 1'b1;
        @(posedge clk);
        #1;
        redirect_valid = 1'b0;
        run_stream(1'b0);
    endtask

    task automatic test_hold_and_flush();
        begin_test("stall, wait and flush");
        load_mixed_program();
        restart();
        run_stream(1'b1);
        restart();
        check_value("valid_o", 32'(valid), 32'd0);
        check_value("mem_pc_o", 32'(mem_pc), 32'(RESET_PC));
        run_stream(1'b0);  // same stream again from RESET_PC
    endtask

    initial begin
        void'($urandom(32'hfb95));
        stall          = 1'b0;
        flush          = 1'b0;
        mem_wait       = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        base           = 0;
        load_pc        = RESET_PC;
        checks         = 0;
        errors         = 0;
        fill_memory();
        @(posedge rst_n);
        test_aligned_stream();
        test_compressed();
        test_split();
        test_redirect();
        test_hold_and_flush();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // released 1 ns after an edge, same as the other inputs
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule
